//--- Makefile
# Verilator build and run for the heap testbench
VERILATOR ?= verilator
TOP       ?= heapMemoryTest
FILELIST  ?= heapMemory.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing --assert
PASS_TEXT ?= sim passed

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(OBJ_DIR) -f $(FILELIST)

run: compile
	@output="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$output"; \
	echo "$$output" | grep -qx "$(PASS_TEXT)"

clean:
	rm -rf $(OBJ_DIR)

//--- heapMemory.f
+incdir+source
source/heapPackage.sv
source/heapControl.sv
source/arrayAllocator.sv
source/elementStore.sv
source/heapMemory.sv
testbench/heapMemoryTest.sv

//--- source/arrayAllocator.sv
//----------------------------------------------------------------------
// Array allocator with high-water counter and LIFO of freed arrays
// Per-array allocated flags
//----------------------------------------------------------------------
`include "heapMemory_config.svh"
`timescale 1ns/1ns
`default_nettype none

module arrayAllocator (
  input  logic                               clock,
  input  logic                               resetN,
  input  logic                               allocStrobe,
  input  logic                               freeStrobe,
  input  heapPackage::arrayNumber            freeArray,
  output heapPackage::arraySize              highWater,
  output heapPackage::arraySize              freeTop,
  output logic [(1 << `HEAP_ARRAY_BITS)-1:0] allocatedFlags,
  output heapPackage::arrayNumber            nextArray
);

  localparam int arrayCount = 1 << `HEAP_ARRAY_BITS;

  heapPackage::arrayNumber freeStack [arrayCount];              // Freed array numbers
  heapPackage::arrayNumber stackTop;                            // Slot of the newest entry

  assign stackTop  = freeTop[`HEAP_ARRAY_BITS-1:0] - heapPackage::arrayNumber'(1);
  assign nextArray = (freeTop != '0) ? freeStack[stackTop]      // Reuse first
                                     : highWater[`HEAP_ARRAY_BITS-1:0];

  always_ff @(posedge clock or negedge resetN) begin
    if (!resetN) begin
      highWater      <= '0;
      freeTop        <= '0;
      allocatedFlags <= '0;
    end else if (allocStrobe) begin
      if (freeTop != '0) begin
        freeTop <= freeTop - heapPackage::arraySize'(1);        // Pop the stack
      end else begin
        highWater <= highWater + heapPackage::arraySize'(1);    // Fresh array
      end
      allocatedFlags[nextArray] <= 1'b1;
    end else if (freeStrobe) begin
      freeTop                   <= freeTop + heapPackage::arraySize'(1);
      allocatedFlags[freeArray] <= 1'b0;
    end
  end

  // Stack storage
  always_ff @(posedge clock) begin
    if (freeStrobe) begin
      freeStack[freeTop[`HEAP_ARRAY_BITS-1:0]] <= freeArray;
    end
  end

  stackDepth: assert property (@(posedge clock) disable iff (!resetN)
    freeTop <= heapPackage::arraySize'(arrayCount))
    else $error("Free stack holds more than %0d arrays", arrayCount);

  oneStrobe: assert property (@(posedge clock) disable iff (!resetN)
    !(allocStrobe && freeStrobe))
    else $error("Alloc and free in the same cycle");

endmodule

`default_nettype wire

//--- source/elementStore.sv
//----------------------------------------------------------------------
// Element memory and per-array size table
// Read, write, push, pop and add datapaths
//----------------------------------------------------------------------
`include "heapMemory_config.svh"
`timescale 1ns/1ns
`default_nettype none

module elementStore (
  input  logic                    clock,
  input  logic                    resetN,
  input  heapPackage::heapAction  storeOp,
  input  logic                    storeStrobe,
  input  heapPackage::heapCommand latched,
  input  logic                    clearStrobe,
  input  heapPackage::arrayNumber clearArray,
  output heapPackage::arraySize   arraySizeNow,
  output heapPackage::elementData elementValue
);

  localparam int arrayCount  = 1 << `HEAP_ARRAY_BITS;
  localparam int arrayLength = 1 << `HEAP_INDEX_BITS;

  heapPackage::elementData  elements [arrayCount][arrayLength]; // Fixed blocks per array
  heapPackage::arraySize    sizes [arrayCount];
  heapPackage::arraySize    indexSize;                          // Index widened to a size
  heapPackage::elementData  current;                            // Addressed element
  heapPackage::elementData  sum;
  heapPackage::elementIndex topIndex;                           // Slot past the last element
  heapPackage::elementIndex lastIndex;

  assign arraySizeNow = sizes[latched.array];
  assign indexSize    = heapPackage::arraySize'(latched.index);
  assign current      = elements[latched.array][latched.index];
  assign sum          = current + latched.data;                 // Wraps at data width
  assign topIndex     = arraySizeNow[`HEAP_INDEX_BITS-1:0];
  assign lastIndex    = topIndex - heapPackage::elementIndex'(1);

  //--------------------------------------------------------------------
  // Element datapath
  //--------------------------------------------------------------------
  always_ff @(posedge clock) begin
    if (storeStrobe) begin
      case (storeOp)
        heapPackage::write: begin
          elements[latched.array][latched.index] <= latched.data;
          elementValue                           <= latched.data;
        end
        heapPackage::push: begin
          elements[latched.array][topIndex] <= latched.data;
          elementValue                      <= latched.data;
        end
        heapPackage::pop: elementValue <= elements[latched.array][lastIndex];
        heapPackage::add: begin
          elements[latched.array][latched.index] <= sum;
          elementValue                           <= sum;    // New value goes back
        end
        default: elementValue <= current;                   // Read
      endcase
    end
  end

  // Size table
  always_ff @(posedge clock or negedge resetN) begin
    if (!resetN) begin
      for (int a = 0; a < arrayCount; a++) begin
        sizes[a] <= '0;
      end
    end else if (clearStrobe) begin
      sizes[clearArray] <= '0;                              // Fresh alloc
    end else if (storeStrobe) begin
      case (storeOp)
        heapPackage::write: begin
          if (indexSize >= arraySizeNow) begin
            sizes[latched.array] <= indexSize + heapPackage::arraySize'(1);
          end
        end
        heapPackage::push: sizes[latched.array] <= arraySizeNow + heapPackage::arraySize'(1);
        heapPackage::pop:  sizes[latched.array] <= arraySizeNow - heapPackage::arraySize'(1);
        default: sizes[latched.array] <= arraySizeNow;
      endcase
    end
  end

  for (genvar a = 0; a < arrayCount; a++) begin : sizeCheck
    sizeBound: assert property (@(posedge clock) disable iff (!resetN)
      sizes[a] <= heapPackage::arraySize'(arrayLength))
      else $error("Array %0d grew past %0d elements", a, arrayLength);
  end

endmodule

`default_nettype wire

//--- source/heapControl.sv
//----------------------------------------------------------------------
// Command FSM for the heap
// Latches a command, checks it, fires the update strobes and replies
//----------------------------------------------------------------------
`include "heapMemory_config.svh"
`timescale 1ns/1ns
`default_nettype none

module heapControl (
  input  logic                               clock,
  input  logic                               resetN,
  input  logic                               commandValid,
  input  heapPackage::heapCommand            command,
  input  heapPackage::arraySize              highWater,
  input  heapPackage::arraySize              freeTop,
  input  logic [(1 << `HEAP_ARRAY_BITS)-1:0] allocatedFlags,
  input  heapPackage::arrayNumber            nextArray,
  input  heapPackage::arraySize              arraySizeNow,
  input  heapPackage::elementData            elementValue,
  output logic                               allocStrobe,
  output logic                               freeStrobe,
  output heapPackage::heapAction             storeOp,
  output logic                               storeStrobe,
  output heapPackage::heapCommand            latched,
  output logic                               clearStrobe,
  output heapPackage::arrayNumber            clearArray,
  output logic                               busy,
  output logic                               done,
  output heapPackage::heapResponse           response
);

  localparam int arrayCount  = 1 << `HEAP_ARRAY_BITS;
  localparam int arrayLength = 1 << `HEAP_INDEX_BITS;

  typedef enum logic [1:0] {
    stateIdle,
    stateCheck,
    stateExecute,
    stateReply
  } controlState;

  controlState             state;
  heapPackage::heapError   checkError;                          // Verdict in the check cycle
  heapPackage::heapError   errorCode;                           // Held until the reply
  heapPackage::elementData replyData;
  logic                    executing;                           // Execute cycle with no error

  //--------------------------------------------------------------------
  // Error rules, first match wins
  //--------------------------------------------------------------------
  always_comb begin
    checkError = heapPackage::none;
    if (latched.action == heapPackage::alloc) begin
      if (freeTop == '0 && highWater >= heapPackage::arraySize'(arrayCount)) begin
        checkError = heapPackage::outOfMemory;                  // Stack empty, counter spent
      end
    end else if (heapPackage::arraySize'(latched.array) >= highWater) begin
      checkError = heapPackage::notAllocated;
    end else if (!allocatedFlags[latched.array]) begin
      checkError = heapPackage::freed;                          // Catches double free too
    end else begin
      case (latched.action)
        heapPackage::read, heapPackage::add: begin
          if (heapPackage::arraySize'(latched.index) >= arraySizeNow) begin
            checkError = heapPackage::outOfBounds;
          end
        end
        heapPackage::push: begin
          if (arraySizeNow == heapPackage::arraySize'(arrayLength)) begin
            checkError = heapPackage::full;
          end
        end
        heapPackage::pop: begin
          if (arraySizeNow == '0) begin
            checkError = heapPackage::empty;
          end
        end
        default: checkError = heapPackage::none;
      endcase
    end
  end

  always_ff @(posedge clock or negedge resetN) begin
    if (!resetN) begin
      state     <= stateIdle;
      errorCode <= heapPackage::none;
      done      <= 1'b0;
      response  <= '0;
    end else begin
      done <= 1'b0;                                             // Single cycle pulse
      case (state)
        stateIdle: begin
          if (commandValid) begin
            state <= stateCheck;
          end
        end
        stateCheck: begin
          errorCode <= checkError;
          state     <= stateExecute;
        end
        stateExecute: state <= stateReply;
        stateReply: begin
          response.data  <= replyData;
          response.error <= errorCode;
          done           <= 1'b1;
          state          <= stateIdle;
        end
        default: state <= stateIdle;
      endcase
    end
  end

  // Command and alloc target
  always_ff @(posedge clock) begin
    if (state == stateIdle && commandValid) begin
      latched <= command;                                       // Ignored while busy
    end
    if (state == stateCheck) begin
      clearArray <= nextArray;                                  // Array the alloc will get
    end
  end

  //--------------------------------------------------------------------
  // Strobes and reply data
  //--------------------------------------------------------------------
  assign executing   = state == stateExecute && errorCode == heapPackage::none;
  assign allocStrobe = executing && latched.action == heapPackage::alloc;
  assign clearStrobe = allocStrobe;                             // New array starts empty
  assign freeStrobe  = executing && latched.action == heapPackage::free;
  assign storeStrobe = storeOp != heapPackage::idle;
  assign busy        = state != stateIdle;

  always_comb begin
    case (latched.action)
      heapPackage::write, heapPackage::read, heapPackage::push,
      heapPackage::pop, heapPackage::add: begin
        storeOp = executing ? latched.action : heapPackage::idle;
      end
      default: storeOp = heapPackage::idle;                     // Size, alloc, free skip the store
    endcase
  end

  always_comb begin
    case (latched.action)
      heapPackage::size:  replyData = heapPackage::elementData'(arraySizeNow);
      heapPackage::alloc: replyData = heapPackage::elementData'(clearArray);
      heapPackage::free:  replyData = '0;
      default:            replyData = elementValue;             // Registered by the store
    endcase
    if (errorCode != heapPackage::none) begin
      replyData = '0;
    end
  end

  commandWhileBusy: assert property (@(posedge clock) disable iff (!resetN)
    commandValid |-> !busy)
    else $error("Command sent while the heap is busy");

  allocTargetFree: assert property (@(posedge clock) disable iff (!resetN)
    state == stateCheck && latched.action == heapPackage::alloc &&
    checkError == heapPackage::none |-> !allocatedFlags[nextArray])
    else $error("Alloc would hand out an array that is still in use");

endmodule

`default_nettype wire

//--- source/heapMemory.sv
//----------------------------------------------------------------------
// Heap top level
// Control FSM, array allocator and element store
//----------------------------------------------------------------------
`include "heapMemory_config.svh"
`timescale 1ns/1ns
`default_nettype none

module heapMemory (
  input  logic                     clock,
  input  logic                     resetN,
  input  logic                     commandValid,
  input  heapPackage::heapCommand  command,
  output logic                     busy,
  output logic                     done,
  output heapPackage::heapResponse response
);

  logic                               allocStrobe;
  logic                               freeStrobe;
  logic                               storeStrobe;
  logic                               clearStrobe;
  heapPackage::heapAction             storeOp;
  heapPackage::heapCommand            latched;              // Command under execution
  heapPackage::arrayNumber            clearArray;
  heapPackage::arrayNumber            nextArray;
  heapPackage::arraySize              highWater;
  heapPackage::arraySize              freeTop;
  heapPackage::arraySize              arraySizeNow;
  heapPackage::elementData            elementValue;
  logic [(1 << `HEAP_ARRAY_BITS)-1:0] allocatedFlags;

  heapControl control0 (
    .clock          (clock),
    .resetN         (resetN),
    .commandValid   (commandValid),
    .command        (command),
    .highWater      (highWater),
    .freeTop        (freeTop),
    .allocatedFlags (allocatedFlags),
    .nextArray      (nextArray),
    .arraySizeNow   (arraySizeNow),
    .elementValue   (elementValue),
    .allocStrobe    (allocStrobe),
    .freeStrobe     (freeStrobe),
    .storeOp        (storeOp),
    .storeStrobe    (storeStrobe),
    .latched        (latched),
    .clearStrobe    (clearStrobe),
    .clearArray     (clearArray),
    .busy           (busy),
    .done           (done),
    .response       (response)
  );

  arrayAllocator allocator0 (
    .clock          (clock),
    .resetN         (resetN),
    .allocStrobe    (allocStrobe),
    .freeStrobe     (freeStrobe),
    .freeArray      (latched.array),                        // Free targets the latched array
    .highWater      (highWater),
    .freeTop        (freeTop),
    .allocatedFlags (allocatedFlags),
    .nextArray      (nextArray)
  );

  elementStore store0 (
    .clock        (clock),
    .resetN       (resetN),
    .storeOp      (storeOp),
    .storeStrobe  (storeStrobe),
    .latched      (latched),
    .clearStrobe  (clearStrobe),
    .clearArray   (clearArray),
    .arraySizeNow (arraySizeNow),
    .elementValue (elementValue)
  );

endmodule

`default_nettype wire

//--- source/heapMemory_config.svh
//----------------------------------------------------------------------
// Width settings for the heap of fixed-size arrays
// Array number, element index and element data widths
//----------------------------------------------------------------------
`ifndef HEAP_MEMORY_CONFIG_SVH
`define HEAP_MEMORY_CONFIG_SVH

// Four arrays on the heap
`define HEAP_ARRAY_BITS 2

// Eight elements per array
`define HEAP_INDEX_BITS 3

// Element width
`define HEAP_DATA_BITS 12

`endif

//--- source/heapPackage.sv
//----------------------------------------------------------------------
// Heap types with widths, action and error codes
// Command and response structs for the host side
//----------------------------------------------------------------------
`include "heapMemory_config.svh"
`default_nettype none

package heapPackage;

  typedef logic [`HEAP_ARRAY_BITS-1:0] arrayNumber;             // Which array
  typedef logic [`HEAP_INDEX_BITS-1:0] elementIndex;            // Slot inside an array
  typedef logic [`HEAP_INDEX_BITS:0]   arraySize;               // Extra bit for a full array
  typedef logic [`HEAP_DATA_BITS-1:0]  elementData;             // One element

  // Host actions, numbering kept from the older heap
  typedef enum logic [7:0] {
    idle  = 8'd0,                                               // No store operation
    write = 8'd2,                                               // Write an element
    read  = 8'd3,                                               // Read an element
    size  = 8'd4,                                               // Size of an array
    push  = 8'd14,                                              // Append at the end
    pop   = 8'd15,                                              // Remove from the end
    alloc = 8'd18,                                              // New or reused array
    free  = 8'd19,                                              // Return an array
    add   = 8'd20                                               // Add into an element
  } heapAction;

  typedef enum logic [2:0] {
    none,                                                       // Command succeeded
    notAllocated,                                               // Array never handed out
    freed,                                                      // Array is on the free stack
    outOfBounds,                                                // Index past the size
    full,                                                       // Push on a full array
    empty,                                                      // Pop on an empty array
    outOfMemory                                                 // No array left
  } heapError;

  typedef struct packed {
    heapAction   action;
    arrayNumber  array;
    elementIndex index;
    elementData  data;
  } heapCommand;

  typedef struct packed {
    elementData data;
    heapError   error;
  } heapResponse;

endpackage

`default_nettype wire

//--- testbench/heapMemoryTest.sv
//----------------------------------------------------------------------
// Testbench for the heap of fixed-size arrays
// Clock, reset, directed and random commands, reference model, checker
//----------------------------------------------------------------------
`include "heapMemory_config.svh"
`timescale 1ns/1ns
`default_nettype none

module heapMemoryTest;

  localparam int arrayCount    = 1 << `HEAP_ARRAY_BITS;
  localparam int arrayLength   = 1 << `HEAP_INDEX_BITS;
  localparam int resetCycles   = 10;
  localparam int randomCount   = 300;
  localparam int commandBudget = 400;                           // Directed plus random
  localparam int timeoutCycles = commandBudget * 4 + 900;       // Resets, test gaps, margin
  localparam int randomSeed    = 32'h6bb0_6639;

  logic                     clock;
  logic                     resetN;
  logic                     commandValid;
  heapPackage::heapCommand  command;
  logic                     busy;
  logic                     done;
  heapPackage::heapResponse response;

  // Reference model state
  int                      modelHighWater;
  int                      modelFreeTop;
  int                      modelStack [arrayCount];             // Freed arrays, newest on top
  bit                      modelFlags [arrayCount];
  int                      modelSizes [arrayCount];
  heapPackage::elementData modelElements [arrayCount][arrayLength];

  heapPackage::heapResponse expectQueue [$];                    // One entry per command in flight
  heapPackage::heapResponse expected;
  int    errorCount = 0;
  int    checkCount = 0;
  int    testCount  = 0;
  int    testErrors = 0;                                        // Counts at test start
  int    testChecks = 0;
  int    cycleCount = 0;
  int    seedValue;
  string testName;

  heapMemory dut0 (
    .clock        (clock),
    .resetN       (resetN),
    .commandValid (commandValid),
    .command      (command),
    .busy         (busy),
    .done         (done),
    .response     (response)
  );

  initial begin
    clock = 1'b0;
    forever #50 clock = ~clock;                                 // 100 ns period
  end

  //--------------------------------------------------------------------
  // Reference model
  //--------------------------------------------------------------------
  function automatic heapPackage::heapResponse heapModel(input heapPackage::heapCommand cmd);
    heapPackage::heapResponse result;
    int a;
    int i;
    result.data  = '0;
    result.error = heapPackage::none;
    a = int'(cmd.array);
    i = int'(cmd.index);
    if (cmd.action == heapPackage::alloc) begin
      if (modelFreeTop > 0) begin
        modelFreeTop--;
        a = modelStack[modelFreeTop];                           // Newest freed array first
      end else if (modelHighWater < arrayCount) begin
        a = modelHighWater;
        modelHighWater++;
      end else begin
        result.error = heapPackage::outOfMemory;
      end
      if (result.error == heapPackage::none) begin
        modelFlags[a] = 1'b1;
        modelSizes[a] = 0;                                      // New array starts empty
        result.data   = heapPackage::elementData'(a);
      end
    end else if (a >= modelHighWater) begin
      result.error = heapPackage::notAllocated;
    end else if (!modelFlags[a]) begin
      result.error = heapPackage::freed;
    end else begin
      case (cmd.action)
        heapPackage::write: begin
          modelElements[a][i] = cmd.data;
          if (i >= modelSizes[a]) begin
            modelSizes[a] = i + 1;                              // Write past the end grows it
          end
          result.data = cmd.data;
        end
        heapPackage::read: begin
          if (i >= modelSizes[a]) begin
            result.error = heapPackage::outOfBounds;
          end else begin
            result.data = modelElements[a][i];
          end
        end
        heapPackage::size: result.data = heapPackage::elementData'(modelSizes[a]);
        heapPackage::push: begin
          if (modelSizes[a] == arrayLength) begin
            result.error = heapPackage::full;
          end else begin
            modelElements[a][modelSizes[a]] = cmd.data;
            modelSizes[a]++;
            result.data = cmd.data;
          end
        end
        heapPackage::pop: begin
          if (modelSizes[a] == 0) begin
            result.error = heapPackage::empty;
          end else begin
            modelSizes[a]--;
            result.data = modelElements[a][modelSizes[a]];      // Removed element
          end
        end
        heapPackage::free: begin
          modelStack[modelFreeTop] = a;
          modelFreeTop++;
          modelFlags[a] = 1'b0;
        end
        heapPackage::add: begin
          if (i >= modelSizes[a]) begin
            result.error = heapPackage::outOfBounds;
          end else begin
            modelElements[a][i] = modelElements[a][i] + cmd.data; // Wraps at 12 bits
            result.data = modelElements[a][i];
          end
        end
        default: result.error = heapPackage::none;
      endcase
    end
    return result;
  endfunction

  // Preload value, spread over array and index
  function automatic int fillValue(input int array, input int index);
    return ((array * arrayLength + index) * 331 + 'h5a5) % 4096;
  endfunction

  function automatic heapPackage::heapAction pickAction(input int pick);
    heapPackage::heapAction action;
    case (pick)
      0:       action = heapPackage::write;
      1:       action = heapPackage::read;
      2:       action = heapPackage::size;
      3:       action = heapPackage::push;
      4:       action = heapPackage::pop;
      5:       action = heapPackage::alloc;
      6:       action = heapPackage::free;
      default: action = heapPackage::add;
    endcase
    return action;
  endfunction

  //--------------------------------------------------------------------
  // Driver, called on a falling edge
  //--------------------------------------------------------------------
  task automatic sendCommand(input heapPackage::heapAction action, input int array,
                             input int index, input int data);
    heapPackage::heapCommand cmd;
    cmd.action = action;
    cmd.array  = heapPackage::arrayNumber'(array);
    cmd.index  = heapPackage::elementIndex'(index);
    cmd.data   = heapPackage::elementData'(data);
    expectQueue.push_back(heapModel(cmd));
    command      = cmd;
    commandValid = 1'b1;                                        // Single cycle strobe
    @(negedge clock);
    commandValid = 1'b0;
    while (!done) begin
      assert (busy === 1'b1) else begin
        errorCount++;
        $display("Error: busy is 0x%0h, expected 0x1", busy);
      end
      @(negedge clock);
    end
    assert (busy === 1'b0) else begin
      errorCount++;
      $display("Error: busy is 0x%0h with done, expected 0x0", busy);
    end
  endtask

  task automatic applyReset;
    @(negedge clock);
    resetN = 1'b0;
    repeat (resetCycles) @(negedge clock);
    resetN         = 1'b1;
    modelHighWater = 0;
    modelFreeTop   = 0;
    for (int a = 0; a < arrayCount; a++) begin
      modelFlags[a] = 1'b0;
      modelSizes[a] = 0;                                        // Elements survive a reset
    end
    expectQueue.delete();
  endtask

  task automatic startTest(input string name);
    testName   = name;
    testErrors = errorCount;
    testChecks = checkCount;
  endtask

  task automatic finishTest;
    @(posedge clock);                                           // Checker has seen the last reply
    testCount++;
    $display("Test %0d %s: %0d replies checked, %0d errors", testCount, testName,
             checkCount - testChecks, errorCount - testErrors);
    @(negedge clock);
  endtask

  //--------------------------------------------------------------------
  // Tests
  //--------------------------------------------------------------------
  task automatic preloadTest;
    startTest("preload every element");
    for (int a = 0; a < arrayCount; a++) begin
      sendCommand(heapPackage::alloc, 0, 0, 0);
    end
    for (int a = 0; a < arrayCount; a++) begin
      for (int i = 0; i < arrayLength; i++) begin
        sendCommand(heapPackage::write, a, i, fillValue(a, i));
      end
    end
    finishTest;
  endtask

  task automatic allocLimitTest;
    startTest("alloc until out of memory");
    sendCommand(heapPackage::size, 2, 0, 0);                    // Never handed out
    for (int n = 0; n <= arrayCount; n++) begin
      sendCommand(heapPackage::alloc, 0, 0, 0);                 // Last one runs dry
    end
    finishTest;
  endtask

  task automatic writeReadTest;
    startTest("write past the end and read back");
    sendCommand(heapPackage::write, 0, 5, 'h3c7);
    sendCommand(heapPackage::size, 0, 0, 0);
    sendCommand(heapPackage::read, 0, 5, 0);
    sendCommand(heapPackage::read, 0, 6, 0);                    // Just past the size
    finishTest;
  endtask

  task automatic pushPopTest;
    startTest("push until full, pop until empty");
    for (int k = 0; k <= arrayLength; k++) begin
      sendCommand(heapPackage::push, 1, 0, 'h100 + k * 'h11);
    end
    for (int k = 0; k <= arrayLength; k++) begin
      sendCommand(heapPackage::pop, 1, 0, 0);
    end
    finishTest;
  endtask

  task automatic freeReuseTest;
    startTest("free and reuse arrays");
    sendCommand(heapPackage::write, 2, 3, 'h2a5);               // Both arrays grow before the free
    sendCommand(heapPackage::push, 1, 0, 'h1b4);
    sendCommand(heapPackage::free, 2, 0, 0);
    sendCommand(heapPackage::free, 1, 0, 0);
    sendCommand(heapPackage::alloc, 0, 0, 0);                   // Gets 1 back
    sendCommand(heapPackage::size, 1, 0, 0);
    sendCommand(heapPackage::alloc, 0, 0, 0);                   // Then 2
    sendCommand(heapPackage::size, 2, 0, 0);
    sendCommand(heapPackage::free, 3, 0, 0);
    sendCommand(heapPackage::read, 3, 0, 0);                    // Access after free
    sendCommand(heapPackage::free, 3, 0, 0);                    // Double free
    sendCommand(heapPackage::alloc, 0, 0, 0);
    finishTest;
  endtask

  task automatic addWrapTest;
    startTest("add with wrap");
    sendCommand(heapPackage::write, 0, 2, 'hf80);
    sendCommand(heapPackage::add, 0, 2, 'h0a0);                 // Carries out of 12 bits
    sendCommand(heapPackage::read, 0, 2, 0);
    finishTest;
  endtask

  task automatic randomTest;
    startTest("random commands");
    for (int n = 0; n < randomCount; n++) begin
      sendCommand(pickAction($urandom_range(7, 0)), $urandom_range(arrayCount - 1, 0),
                  $urandom_range(arrayLength - 1, 0), $urandom_range(4095, 0));
    end
    finishTest;
  endtask

  //--------------------------------------------------------------------
  // Checker, samples on the falling edge
  //--------------------------------------------------------------------
  always @(negedge clock) begin
    if (resetN && done) begin
      checkCount++;
      assert (expectQueue.size() > 0) else begin
        errorCount++;
        $display("Done pulsed with no command outstanding");
      end
      if (expectQueue.size() > 0) begin
        expected = expectQueue.pop_front();
        assert (response.data === expected.data) else begin
          errorCount++;
          $display("Error: response.data is 0x%03h, expected 0x%03h",
                   response.data, expected.data);
        end
        assert (response.error === expected.error) else begin
          errorCount++;
          $display("Error: response.error is 0x%0h, expected 0x%0h",
                   response.error, expected.error);
        end
      end
    end
  end

  // Watchdog
  initial begin
    while (cycleCount < timeoutCycles) begin
      @(posedge clock);
      cycleCount++;
    end
    $display("Timeout after %0d cycles, the heap stopped answering", timeoutCycles);
    $display("sim failed");
    $finish;
  end

  initial begin
    seedValue    = $urandom(randomSeed);                        // Seeds the run once
    resetN       = 1'b0;
    commandValid = 1'b0;
    command      = '0;
    applyReset;
    preloadTest;
    applyReset;                                                 // Clean state, memory kept
    allocLimitTest;
    writeReadTest;
    pushPopTest;
    freeReuseTest;
    addWrapTest;
    randomTest;
    $display("Summary: %0d tests, %0d replies checked, %0d errors",
             testCount, checkCount, errorCount);
    if (errorCount == 0 && expectQueue.size() == 0) begin
      $display("sim passed");
    end else begin
      $display("sim failed");
    end
    $finish;
  end

endmodule

`default_nettype wire
